// ==== busPkg.sv ====
package busPkg;

   // Datapath word size
   localparam int dataWidth = 8;

   // Bus register file
   localparam int numRegs = 4;

   // Registers hardwired to the ALU operands
   localparam int regA = 0;  // Left operand, also the shift source
   localparam int regB = 1;  // Right operand

   // Bus source select
   localparam int srcWidth = 3;

   localparam logic [srcWidth-1:0] srcReg0  = 3'd0;
   localparam logic [srcWidth-1:0] srcReg1  = 3'd1;
   localparam logic [srcWidth-1:0] srcReg2  = 3'd2;
   localparam logic [srcWidth-1:0] srcReg3  = 3'd3;
   localparam logic [srcWidth-1:0] srcSum   = 3'd4;  // Adder/subtractor output
   localparam logic [srcWidth-1:0] srcShift = 3'd5;  // Right shifter output
   localparam logic [srcWidth-1:0] srcExt   = 3'd6;  // External data input

   // Nobody drives, bus reads zero
   localparam logic [srcWidth-1:0] srcNone  = 3'd7;

   // One assert line per real source, srcNone has none
   localparam int numSrc = 7;

endpackage

// ==== microDecoder.sv ====
`timescale 1ns/1ps

module microDecoder import busPkg::*; (
   input  logic                clk,
   input  logic                rst,
   input  logic                opValid,
   input  logic [srcWidth-1:0] opSrc,
   input  logic [numRegs-1:0]  opLoad,
   input  logic [numRegs-1:0]  opInc,
   input  logic                opSubtract,
   input  logic                opTrigC,
   input  logic                opTrigS,
   input  logic                opEmit,
   output logic [numSrc-1:0]   assertEn,
   output logic [numRegs-1:0]  loadEn,
   output logic [numRegs-1:0]  incEn,
   output logic                doSubtract,
   output logic                triggerC,
   output logic                triggerS,
   output logic                emit
);

   logic [numSrc-1:0] srcOneHot;

   // Source code to one-hot assert line
   always_comb begin
      srcOneHot = '0;
      case (opSrc)
         srcReg0:  srcOneHot[srcReg0]  = 1'b1;
         srcReg1:  srcOneHot[srcReg1]  = 1'b1;
         srcReg2:  srcOneHot[srcReg2]  = 1'b1;
         srcReg3:  srcOneHot[srcReg3]  = 1'b1;
         srcSum:   srcOneHot[srcSum]   = 1'b1;
         srcShift: srcOneHot[srcShift] = 1'b1;
         srcExt:   srcOneHot[srcExt]   = 1'b1;
         srcNone:  srcOneHot           = '0;  // Bus left undriven
      endcase
   end

   // Strobes live for exactly one cycle after the op is sampled
   always_ff @(posedge clk) begin
      if (rst || !opValid) begin
         assertEn   <= '0;
         loadEn     <= '0;
         incEn      <= '0;
         doSubtract <= 1'b0;
         triggerC   <= 1'b0;
         triggerS   <= 1'b0;
         emit       <= 1'b0;
      end else begin
         assertEn   <= srcOneHot;
         loadEn     <= opLoad;
         incEn      <= opInc;
         doSubtract <= opSubtract;
         triggerC   <= opTrigC;
         triggerS   <= opTrigS;
         // Emit even with no source, read port then sees zero
         emit       <= opEmit;
      end
   end

endmodule

// ==== busRegister.sv ====
`timescale 1ns/1ps

module busRegister import busPkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 load,
   input  logic                 inc,
   input  logic [dataWidth-1:0] bus,
   output logic [dataWidth-1:0] value
);

   logic [dataWidth-1:0] valueNext;

   // Load has priority over increment
   always_comb begin
      valueNext = value;
      if (load) begin
         valueNext = bus;
      end else if (inc) begin
         valueNext = value + 1'b1;  // Wraps to zero from all ones
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         value <= '0;
      end else begin
         value <= valueNext;
      end
   end

endmodule

// ==== aluNet.sv ====
`timescale 1ns/1ps

module aluNet import busPkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 doSubtract,
   input  logic                 triggerC,
   input  logic                 triggerS,
   input  logic [dataWidth-1:0] areg,
   input  logic [dataWidth-1:0] breg,
   output logic [dataWidth-1:0] sum,
   output logic [dataWidth-1:0] shifted,
   output logic                 aIsZero,
   output logic                 flagCarry,
   output logic                 flagShift
);

   logic [dataWidth-1:0] other;     // B or its complement
   logic [dataWidth:0]   fullSum;   // Sum with carry out on top
   logic                 carryOut;

   // Subtract is A + ~B + 1
   assign other = breg ^ {dataWidth{doSubtract}};

   assign fullSum = {1'b0, areg} + {1'b0, other} + {{dataWidth{1'b0}}, doSubtract};

   assign sum      = fullSum[dataWidth-1:0];
   assign carryOut = fullSum[dataWidth];  // High means no borrow when subtracting

   // Rotate through the shift flag, old flag enters at the top
   assign shifted = {flagShift, areg[dataWidth-1:1]};

   assign aIsZero = ~|areg;

   // Carry flag
   always_ff @(posedge clk) begin
      if (rst) begin
         flagCarry <= 1'b0;
      end else if (triggerC) begin
         flagCarry <= carryOut;
      end
   end

   // Shift flag catches the bit falling out of A
   always_ff @(posedge clk) begin
      if (rst) begin
         flagShift <= 1'b0;
      end else if (triggerS) begin
         flagShift <= areg[0];
      end
   end

endmodule

// ==== busDriver.sv ====
`timescale 1ns/1ps

module busDriver import busPkg::*; (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [numSrc-1:0]                  assertEn,
   input  logic                               emit,
   input  logic [numRegs-1:0][dataWidth-1:0]  regValues,
   input  logic [dataWidth-1:0]               sum,
   input  logic [dataWidth-1:0]               shifted,
   input  logic [dataWidth-1:0]               extData,
   output logic [dataWidth-1:0]               bus,
   output logic [dataWidth-1:0]               readData,
   output logic                               readValid
);

   logic [dataWidth-1:0] extSampled;  // extData taken at the same edge as its op

   // External word travels with its micro-operation
   always_ff @(posedge clk) begin
      if (rst) begin
         extSampled <= '0;
      end else begin
         extSampled <= extData;
      end
   end

   // AND-OR mux over one-hot assert lines
   always_comb begin
      bus = '0;
      for (int i = 0; i < numRegs; i++) begin
         if (assertEn[int'(srcReg0) + i]) begin
            bus = bus | regValues[i];
         end
      end
      if (assertEn[srcSum]) begin
         bus = bus | sum;
      end
      if (assertEn[srcShift]) begin
         bus = bus | shifted;
      end
      if (assertEn[srcExt]) begin
         bus = bus | extSampled;
      end
   end

   // Captured word
   always_ff @(posedge clk) begin
      if (emit) begin
         readData <= bus;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         readValid <= 1'b0;
      end else begin
         readValid <= emit;  // One cycle pulse per emit
      end
   end

endmodule

// ==== datapathTop.sv ====
`timescale 1ns/1ps

module datapathTop import busPkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 opValid,
   input  logic [srcWidth-1:0]  opSrc,
   input  logic [numRegs-1:0]   opLoad,
   input  logic [numRegs-1:0]   opInc,
   input  logic                 opSubtract,
   input  logic                 opTrigC,
   input  logic                 opTrigS,
   input  logic                 opEmit,
   input  logic [dataWidth-1:0] extData,
   output logic [dataWidth-1:0] readData,
   output logic                 readValid,
   output logic                 aIsZero,
   output logic                 flagCarry,
   output logic                 flagShift
);

   logic [numSrc-1:0]                 assertEn;
   logic [numRegs-1:0]                loadEn;
   logic [numRegs-1:0]                incEn;
   logic                              doSubtract;
   logic                              triggerC;
   logic                              triggerS;
   logic                              emit;
   logic [dataWidth-1:0]              bus;
   logic [dataWidth-1:0]              sum;
   logic [dataWidth-1:0]              shifted;
   logic [numRegs-1:0][dataWidth-1:0] regValues;

   microDecoder u_decoder (
      .clk(clk), .rst(rst), .opValid(opValid), .opSrc(opSrc),
      .opLoad(opLoad), .opInc(opInc), .opSubtract(opSubtract),
      .opTrigC(opTrigC), .opTrigS(opTrigS), .opEmit(opEmit),
      .assertEn(assertEn), .loadEn(loadEn), .incEn(incEn),
      .doSubtract(doSubtract), .triggerC(triggerC), .triggerS(triggerS), .emit(emit)
   );

   // Register file on the shared bus
   for (genvar i = 0; i < numRegs; i++) begin : genRegs
      busRegister u_reg (
         .clk(clk), .rst(rst), .load(loadEn[i]), .inc(incEn[i]),
         .bus(bus), .value(regValues[i])
      );
   end

   aluNet u_alu (
      .clk(clk), .rst(rst), .doSubtract(doSubtract),
      .triggerC(triggerC), .triggerS(triggerS),
      .areg(regValues[regA]), .breg(regValues[regB]),  // A and B feed the ALU directly
      .sum(sum), .shifted(shifted), .aIsZero(aIsZero),
      .flagCarry(flagCarry), .flagShift(flagShift)
   );

   busDriver u_busDriver (
      .clk(clk), .rst(rst), .assertEn(assertEn), .emit(emit),
      .regValues(regValues), .sum(sum), .shifted(shifted), .extData(extData),
      .bus(bus), .readData(readData), .readValid(readValid)
   );

endmodule

// ==== tb_datapath.sv ====
`timescale 1ns/1ps

module tb_datapath import busPkg::*; ();

   typedef struct packed {
      logic                valid;
      logic [srcWidth-1:0] src;
      logic [numRegs-1:0]  load;
      logic [numRegs-1:0]  inc;
      logic                sub;
      logic                trigC;
      logic                trigS;
      logic                emit;
   } microOpT;

   logic                 clk;
   logic                 rst;
   logic                 opValid;
   logic [srcWidth-1:0]  opSrc;
   logic [numRegs-1:0]   opLoad;
   logic [numRegs-1:0]   opInc;
   logic                 opSubtract;
   logic                 opTrigC;
   logic                 opTrigS;
   logic                 opEmit;
   logic [dataWidth-1:0] extData;
   logic [dataWidth-1:0] readData;
   logic                 readValid;
   logic                 aIsZero;
   logic                 flagCarry;
   logic                 flagShift;

   // Reference model state
   logic [numRegs-1:0][dataWidth-1:0] modelRegs;
   logic                              modelCarry;
   logic                              modelShift;
   microOpT                           inFlight;     // Op whose strobes are live
   logic [dataWidth-1:0]              inFlightExt;  // extData sampled with that op
   logic [dataWidth-1:0]              busModel;
   logic [dataWidth-1:0]              expQ[$];      // Words the read port still owes
   logic [dataWidth-1:0]              expWord;

   int errorCount;
   int timeoutCount;
   bit checkOn;

   datapathTop u_dut (
      .clk(clk), .rst(rst), .opValid(opValid), .opSrc(opSrc),
      .opLoad(opLoad), .opInc(opInc), .opSubtract(opSubtract),
      .opTrigC(opTrigC), .opTrigS(opTrigS), .opEmit(opEmit), .extData(extData),
      .readData(readData), .readValid(readValid), .aIsZero(aIsZero),
      .flagCarry(flagCarry), .flagShift(flagShift)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Applies one micro-operation to the model and returns its bus value
   function automatic logic [dataWidth-1:0] referenceStep(
      input microOpT                              op,
      input logic [dataWidth-1:0]                 ext,
      inout logic [numRegs-1:0][dataWidth-1:0]    regs,
      inout logic                                 carry,
      inout logic                                 shiftFlag
   );
      logic [dataWidth-1:0] busVal;
      logic [dataWidth-1:0] aVal;
      logic [dataWidth-1:0] bVal;
      logic [dataWidth-1:0] aluVal;
      logic                 aluCarry;
      aVal = regs[regA];
      bVal = regs[regB];
      if (op.sub) begin
         aluVal   = aVal - bVal;
         aluCarry = (aVal >= bVal);  // Carry set means no borrow
      end else begin
         aluVal   = aVal + bVal;
         aluCarry = (int'(aVal) + int'(bVal)) > 255;
      end
      case (op.src)
         srcReg0, srcReg1, srcReg2, srcReg3: busVal = regs[op.src[1:0]];
         srcSum:   busVal = aluVal;
         srcShift: busVal = (aVal >> 1) | (shiftFlag ? 8'h80 : 8'h00);  // Old flag on top
         srcExt:   busVal = ext;
         default:  busVal = '0;
      endcase
      for (int i = 0; i < numRegs; i++) begin
         if (op.load[i]) begin
            regs[i] = busVal;
         end else if (op.inc[i]) begin
            regs[i] = (regs[i] == 8'hff) ? 8'h00 : regs[i] + 8'h01;
         end
      end
      if (op.trigC) begin
         carry = aluCarry;
      end
      if (op.trigS) begin
         shiftFlag = aVal[0];
      end
      return busVal;
   endfunction

   // Model applies each op one edge after it is sampled
   always @(posedge clk) begin
      if (rst) begin
         modelRegs   = '0;
         modelCarry  = 1'b0;
         modelShift  = 1'b0;
         inFlight    = '0;
         inFlightExt = '0;
      end else begin
         if (inFlight.valid) begin
            busModel = referenceStep(inFlight, inFlightExt, modelRegs, modelCarry, modelShift);
            if (inFlight.emit) begin
               expQ.push_back(busModel);
            end
         end
         inFlight    = {opValid, opSrc, opLoad, opInc, opSubtract, opTrigC, opTrigS, opEmit};
         inFlightExt = extData;
      end
   end

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
         errorCount++;
      end
   endtask

   // Outputs are stable mid-cycle
   always @(negedge clk) begin
      if (checkOn) begin
         checkValue("flagCarry", flagCarry, modelCarry);
         checkValue("flagShift", flagShift, modelShift);
         checkValue("aIsZero", aIsZero, modelRegs[regA] == '0);
         if (readValid === 1'b1) begin
            if (expQ.size() == 0) begin
               $display("Read port delivered a word that no operation emitted at %0t", $time);
               errorCount++;
            end else begin
               expWord = expQ.pop_front();
               checkValue("readData", readData, expWord);
            end
         end else if (readValid !== 1'b0) begin
            $display("readValid is unknown at %0t", $time);
            errorCount++;
         end
      end
   end

   function automatic microOpT makeOp(
      input logic [srcWidth-1:0] src,
      input logic [numRegs-1:0]  load,
      input logic [numRegs-1:0]  inc,
      input logic                sub,
      input logic                trigC,
      input logic                trigS,
      input logic                emit
   );
      microOpT op;
      op = {1'b1, src, load, inc, sub, trigC, trigS, emit};
      return op;
   endfunction

   task automatic driveOp(input microOpT op, input logic [dataWidth-1:0] ext);
      @(posedge clk);
      #2;
      opValid    = op.valid;
      opSrc      = op.src;
      opLoad     = op.load;
      opInc      = op.inc;
      opSubtract = op.sub;
      opTrigC    = op.trigC;
      opTrigS    = op.trigS;
      opEmit     = op.emit;
      extData    = ext;
   endtask

   task automatic idle(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         driveOp('0, '0);
      end
   endtask

   // Last issued op has taken effect when this returns
   task automatic settle();
      idle(2);
   endtask

   task automatic loadReg(input int idx, input logic [dataWidth-1:0] value);
      driveOp(makeOp(srcExt, numRegs'(1 << idx), '0, 0, 0, 0, 0), value);
   endtask

   task automatic emitReg(input int idx);
      driveOp(makeOp(srcWidth'(int'(srcReg0) + idx), '0, '0, 0, 0, 0, 1), '0);
   endtask

   task automatic drainReads(input int limit);
      int waited;
      waited = 0;
      settle();
      while (expQ.size() != 0 && waited < limit) begin
         idle(1);
         waited++;
      end
      if (expQ.size() != 0) begin
         $display("Timed out waiting for %0d emitted words on the read port", expQ.size());
         timeoutCount++;
         expQ.delete();
      end
   endtask

   task automatic resetState();
      checkValue("aIsZero", aIsZero, 1);
      checkValue("flagCarry", flagCarry, 0);
      checkValue("flagShift", flagShift, 0);
      for (int i = 0; i < numRegs; i++) begin
         emitReg(i);
      end
      drainReads(20);
   endtask

   task automatic loadAndEmit();
      logic [dataWidth-1:0] vals [numRegs];
      vals[0] = 8'h5a;
      vals[1] = 8'hc3;
      vals[2] = 8'h81;
      vals[3] = 8'h7e;
      for (int i = 0; i < numRegs; i++) begin
         driveOp(makeOp(srcExt, numRegs'(1 << i), '0, 0, 0, 0, 1), vals[i]);
      end
      for (int i = 0; i < numRegs; i++) begin
         emitReg(i);
      end
      // Second op reads the register the first one writes
      driveOp(makeOp(srcExt, 4'b0100, '0, 0, 0, 0, 0), 8'h99);
      driveOp(makeOp(srcReg2, 4'b1000, '0, 0, 0, 0, 1), '0);
      emitReg(3);
      drainReads(20);
   endtask

   task automatic runAlu(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b,
                         input logic sub, input logic expCarry);
      loadReg(regA, a);
      loadReg(regB, b);
      driveOp(makeOp(srcSum, 4'b0100, '0, sub, 1, 0, 1), '0);  // Result also into reg 2
      settle();
      checkValue("flagCarry", flagCarry, expCarry);
      emitReg(2);
   endtask

   task automatic addAndSubtract();
      runAlu(8'hff, 8'h01, 0, 1);  // Carry out of 255 + 1
      runAlu(8'h12, 8'h34, 0, 0);
      runAlu(8'h10, 8'h05, 1, 1);  // No borrow
      runAlu(8'h05, 8'h10, 1, 0);
      runAlu(8'h80, 8'h80, 1, 1);
      drainReads(20);
   endtask

   task automatic shiftChain();
      // Clear the shift flag with an even A first
      loadReg(regA, 8'h00);
      driveOp(makeOp(srcShift, '0, '0, 0, 0, 1, 0), '0);
      loadReg(regA, 8'hb5);
      for (int i = 0; i < dataWidth + 1; i++) begin
         driveOp(makeOp(srcShift, 4'b0001, '0, 0, 0, 1, 1), '0);
      end
      settle();
      // Nine steps around the 9-bit ring restore A and the flag
      checkValue("flagShift", flagShift, 0);
      checkValue("aIsZero", aIsZero, 0);
      emitReg(regA);
      drainReads(20);
   endtask

   task automatic incrementWrap();
      loadReg(2, 8'hfe);
      driveOp(makeOp(srcNone, '0, 4'b0100, 0, 0, 0, 0), '0);
      driveOp(makeOp(srcNone, '0, 4'b0100, 0, 0, 0, 0), '0);
      emitReg(2);
      // Load beats increment
      driveOp(makeOp(srcExt, 4'b1000, 4'b1000, 0, 0, 0, 1), 8'h33);
      emitReg(3);
      loadReg(regA, 8'hff);
      settle();
      checkValue("aIsZero", aIsZero, 0);
      driveOp(makeOp(srcNone, '0, 4'b0001, 0, 0, 0, 0), '0);
      settle();
      checkValue("aIsZero", aIsZero, 1);
      driveOp(makeOp(srcNone, '0, 4'b0001, 0, 0, 0, 0), '0);
      settle();
      checkValue("aIsZero", aIsZero, 0);
      driveOp(makeOp(srcNone, '0, '0, 0, 0, 0, 1), '0);  // Empty bus reads zero
      drainReads(20);
   endtask

   task automatic randomOps(input int count);
      microOpT op;
      for (int n = 0; n < count; n++) begin
         op.valid = ($urandom % 4) != 0;
         op.src   = srcWidth'($urandom % 8);
         op.load  = (($urandom % 3) == 0) ? numRegs'($urandom % 16) : '0;
         op.inc   = (($urandom % 3) == 0) ? numRegs'($urandom % 16) : '0;
         op.sub   = $urandom % 2;
         op.trigC = $urandom % 2;
         op.trigS = $urandom % 2;
         op.emit  = $urandom % 2;
         driveOp(op, dataWidth'($urandom % 256));
      end
      drainReads(20);
   endtask

   initial begin
      void'($urandom(87));
      errorCount   = 0;
      timeoutCount = 0;
      checkOn      = 1'b0;
      rst          = 1'b1;
      opValid      = 1'b0;
      opSrc        = srcNone;
      opLoad       = '0;
      opInc        = '0;
      opSubtract   = 1'b0;
      opTrigC      = 1'b0;
      opTrigS      = 1'b0;
      opEmit       = 1'b0;
      extData      = '0;
      repeat (10) @(posedge clk);
      #2;
      rst     = 1'b0;
      checkOn = 1'b1;

      resetState();
      loadAndEmit();
      addAndSubtract();
      shiftChain();
      incrementWrap();
      randomOps(300);

      $display("Run complete with %0d value errors and %0d timeouts", errorCount,
               timeoutCount);
      if (errorCount == 0 && timeoutCount == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
busPkg.sv
microDecoder.sv
busRegister.sv
aluNet.sv
busDriver.sv
datapathTop.sv
tb_datapath.sv

// ==== Bender.yml ====
package:
  name: datapath

sources:
  - busPkg.sv
  - microDecoder.sv
  - busRegister.sv
  - aluNet.sv
  - busDriver.sv
  - datapathTop.sv
  - target: simulation
    files:
      - tb_datapath.sv
